//--- src/readout_pkg.sv
/*
 readout package
 widths, buffer depth, channel count and payload words shared by the
 shot sequencing and readout capture core
*/
package readout_pkg;

	// number of readout channels
	localparam int NCHAN = 2;

	// one accumulated component, real or imaginary
	localparam int ACC_W = 32;

	// shot counter and nshot width
	localparam int SHOT_W = 32;

	// shot buffer address bits, 16 entries
	localparam int BUF_AW = 4;

	// shot index bits kept in a measurement word
	localparam int SHOT_IDX_W = 16;

	// accumulated result, real part in the upper half
	typedef struct packed {
		logic signed [ACC_W-1:0] re;
		logic signed [ACC_W-1:0] im;
	} acc_word_t;

	// measurement result
	// state bit on top, low shot index bits below
	typedef struct packed {
		logic state;
		logic [SHOT_IDX_W-1:0] shot;
	} meas_word_t;

	// shot buffer address
	typedef logic [BUF_AW-1:0] buf_addr_t;

endpackage

//--- src/shot_sequencer.sv
/*
 shot sequencer
 runs nshot shots (endless when nshot is zero), one processor reset
 release per shot, and flags the end of the experiment
*/
module shot_sequencer (
	input  logic dspif,
	input  logic rst_n,
	input  logic stb_start,
	input  logic [readout_pkg::SHOT_W-1:0] nshot,
	input  logic proc_done,
	input  logic elem_idle,
	output logic proc_reset,
	output logic last_shot_done,
	output logic [readout_pkg::SHOT_W-1:0] shot_idx
);
	import readout_pkg::*;

	// gray-like codes, neighbouring states differ in one bit
	typedef enum logic [2:0] {
		IDLE     = 3'b000,
		START    = 3'b001,
		PROCRUN  = 3'b011,
		ELEMBUSY = 3'b010,
		MORESHOT = 3'b110,
		SHOTADD  = 3'b111,
		DONE     = 3'b101
	} seq_state_t;

	seq_state_t state;
	seq_state_t next_state;

	// shot count latched at start
	logic [SHOT_W-1:0] nshot_r;

	// registered status from processors and elements
	logic proc_done_r;
	logic elem_idle_r;

	// another shot wanted after the current one
	logic more_shot;

	always_ff @(posedge dspif) begin
		if (!rst_n) begin
			proc_done_r <= 1'b0;
			elem_idle_r <= 1'b0;
		end else begin
			proc_done_r <= proc_done;
			elem_idle_r <= elem_idle;
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			IDLE: begin
				if (stb_start)
					next_state = START;
			end
			START: begin
				next_state = PROCRUN;
			end
			PROCRUN: begin
				if (proc_done_r)
					next_state = ELEMBUSY;
			end
			ELEMBUSY: begin
				if (elem_idle_r)
					next_state = MORESHOT;
			end
			MORESHOT: begin
				next_state = more_shot ? SHOTADD : DONE;
			end
			SHOTADD: begin
				next_state = START;
			end
			DONE: begin
				next_state = IDLE;
			end
			default: begin
				next_state = IDLE;
			end
		endcase
	end

	always_ff @(posedge dspif) begin
		if (!rst_n) begin
			state <= IDLE;
			proc_reset <= 1'b1;
			last_shot_done <= 1'b0;
			shot_idx <= '0;
			nshot_r <= '0;
			more_shot <= 1'b0;
		end else begin
			state <= next_state;
			// processors run only while in PROCRUN
			proc_reset <= (next_state != PROCRUN);
			// compare the next count well ahead of MORESHOT
			more_shot <= (shot_idx + 1'b1 != nshot_r) || (nshot_r == '0);
			if (state == IDLE && stb_start) begin
				nshot_r <= nshot;
				shot_idx <= '0;
			end else if (state == SHOTADD) begin
				shot_idx <= shot_idx + 1'b1;
			end
			// sticky until the next experiment starts
			if (stb_start)
				last_shot_done <= 1'b0;
			else if (state == DONE)
				last_shot_done <= 1'b1;
		end
	end

	// processors held in reset whenever the sequencer is idle
	a_reset_in_idle: assert property (
		@(posedge dspif) disable iff (!rst_n)
		state == IDLE |-> proc_reset
	);

	// end of experiment only after the last shot has been stopped
	a_done_after_reset: assert property (
		@(posedge dspif) disable iff (!rst_n)
		$rose(last_shot_done) |-> proc_reset
	);

endmodule

//--- src/meas_discriminator.sv
/*
 measurement discriminator
 captures one channel's accumulated I/Q result and thresholds the real
 part into a qubit state bit
*/
module meas_discriminator (
	input  logic dspif,
	input  logic rst_n,
	input  logic acc_valid,
	input  logic signed [readout_pkg::ACC_W-1:0] acc_x,
	input  logic signed [readout_pkg::ACC_W-1:0] acc_y,
	input  logic [readout_pkg::SHOT_W-1:0] shot_idx,
	output logic wr_en,
	output readout_pkg::acc_word_t acc_word,
	output readout_pkg::meas_word_t meas_word,
	output logic meas_valid,
	output logic meas_bit
);
	import readout_pkg::*;

	// one strobe for both buffers and the aggregator
	logic valid_q;

	always_ff @(posedge dspif) begin
		if (!rst_n)
			valid_q <= 1'b0;
		else
			valid_q <= acc_valid;
	end

	// result words, loaded only on a new accumulation
	always_ff @(posedge dspif) begin
		if (acc_valid) begin
			acc_word.re <= acc_x;
			acc_word.im <= acc_y;
			// negative real part reads as state 1
			meas_word.state <= acc_x[ACC_W-1];
			meas_word.shot <= shot_idx[SHOT_IDX_W-1:0];
		end
	end

	assign wr_en = valid_q;
	assign meas_valid = valid_q;
	assign meas_bit = meas_word.state;

endmodule

//--- src/shot_buffer.sv
/*
 shot buffer
 16 entry result memory, write pointer locks at the last address,
 registered host read port
*/
module shot_buffer #(
	parameter type entry_t = readout_pkg::acc_word_t
) (
	input  logic dspif,
	input  logic rst_n,
	input  logic acc_reset,
	input  logic wr_en,
	input  entry_t wr_data,
	input  readout_pkg::buf_addr_t rd_addr,
	output entry_t rd_data,
	output readout_pkg::buf_addr_t wr_ptr
);
	import readout_pkg::*;

	entry_t mem [0:(1 << BUF_AW) - 1];

	// pointer sits on the last entry
	logic ptr_last;

	// pointer clear wins over a write
	logic wr_go;

	assign ptr_last = &wr_ptr;
	assign wr_go = wr_en && !acc_reset;

	always_ff @(posedge dspif) begin
		if (!rst_n) begin
			wr_ptr <= '0;
		end else if (acc_reset) begin
			wr_ptr <= '0;
		end else if (wr_en && !ptr_last) begin
			wr_ptr <= wr_ptr + 1'b1;
		end
	end

	// once locked, later shots overwrite the last entry
	always_ff @(posedge dspif) begin
		if (wr_go)
			mem[wr_ptr] <= wr_data;
	end

	// host side, one cycle read latency
	always_ff @(posedge dspif) begin
		rd_data <= mem[rd_addr];
	end

	// pointer only goes back through acc_reset or a reset
	a_ptr_monotonic: assert property (
		@(posedge dspif) disable iff (!rst_n)
		(wr_ptr < $past(wr_ptr)) |-> ($past(acc_reset) || $past(!rst_n))
	);

endmodule

//--- src/meas_aggregator.sv
/*
 measurement aggregator
 gathers one state bit per channel for each shot and strobes
 meas_ready once all channels have reported
*/
module meas_aggregator (
	input  logic dspif,
	input  logic rst_n,
	input  logic proc_reset,
	input  logic [readout_pkg::NCHAN-1:0] meas_valid,
	input  logic [readout_pkg::NCHAN-1:0] meas_bit,
	output logic [readout_pkg::NCHAN-1:0] meas_state,
	output logic meas_ready
);
	import readout_pkg::*;

	// channels already heard from in this shot
	logic [NCHAN-1:0] seen;
	logic [NCHAN-1:0] seen_nxt;

	// bits collected so far
	logic [NCHAN-1:0] pend;
	logic [NCHAN-1:0] pend_nxt;

	// all channels in, counting this cycle's strobes
	logic all_in;

	assign seen_nxt = seen | meas_valid;
	// new bits replace old ones per channel
	assign pend_nxt = (pend & ~meas_valid) | (meas_bit & meas_valid);
	assign all_in = &seen_nxt;

	always_ff @(posedge dspif) begin
		if (!rst_n) begin
			seen <= '0;
			meas_ready <= 1'b0;
		end else if (proc_reset) begin
			// partial shot dropped between shots
			seen <= '0;
			meas_ready <= 1'b0;
		end else if (all_in) begin
			seen <= '0;
			meas_ready <= 1'b1;
		end else begin
			seen <= seen_nxt;
			meas_ready <= 1'b0;
		end
	end

	always_ff @(posedge dspif) begin
		pend <= pend_nxt;
		// published bits hold until the next complete shot
		if (!proc_reset && all_in)
			meas_state <= pend_nxt;
	end

	// one strobe per shot, shots never complete back to back
	a_ready_single: assert property (
		@(posedge dspif) disable iff (!rst_n)
		meas_ready |=> !meas_ready
	);

endmodule

//--- src/readout_top.sv
/*
 readout top
 shot sequencer, per channel discriminator and result buffers,
 and the measurement aggregator
*/
module readout_top (
	input  logic dspif,
	input  logic rst_n,
	input  logic stb_start,
	input  logic [readout_pkg::SHOT_W-1:0] nshot,
	input  logic proc_done,
	input  logic elem_idle,
	input  logic acc_reset,
	input  logic [readout_pkg::NCHAN-1:0] acc_valid,
	input  logic signed [readout_pkg::ACC_W-1:0] acc_x [readout_pkg::NCHAN],
	input  logic signed [readout_pkg::ACC_W-1:0] acc_y [readout_pkg::NCHAN],
	input  readout_pkg::buf_addr_t rd_addr [readout_pkg::NCHAN],
	output logic proc_reset,
	output logic last_shot_done,
	output logic [readout_pkg::SHOT_W-1:0] shot_idx,
	output readout_pkg::acc_word_t acc_rd_data [readout_pkg::NCHAN],
	output readout_pkg::meas_word_t meas_rd_data [readout_pkg::NCHAN],
	output readout_pkg::buf_addr_t wr_ptr [readout_pkg::NCHAN],
	output logic [readout_pkg::NCHAN-1:0] meas_state,
	output logic meas_ready
);
	import readout_pkg::*;

	// per channel strobes and state bits toward the aggregator
	logic [NCHAN-1:0] meas_valid;
	logic [NCHAN-1:0] meas_bit;

	shot_sequencer u_seq (
		.dspif(dspif),
		.rst_n(rst_n),
		.stb_start(stb_start),
		.nshot(nshot),
		.proc_done(proc_done),
		.elem_idle(elem_idle),
		.proc_reset(proc_reset),
		.last_shot_done(last_shot_done),
		.shot_idx(shot_idx)
	);

	for (genvar ch = 0; ch < NCHAN; ch++) begin : g_chan
		logic wr_en;
		acc_word_t acc_word;
		meas_word_t meas_word;

		meas_discriminator u_disc (
			.dspif(dspif),
			.rst_n(rst_n),
			.acc_valid(acc_valid[ch]),
			.acc_x(acc_x[ch]),
			.acc_y(acc_y[ch]),
			.shot_idx(shot_idx),
			.wr_en(wr_en),
			.acc_word(acc_word),
			.meas_word(meas_word),
			.meas_valid(meas_valid[ch]),
			.meas_bit(meas_bit[ch])
		);

		// accumulated words, its pointer is the channel's wr_ptr
		shot_buffer #(.entry_t(acc_word_t)) u_acc_buf (
			.dspif(dspif),
			.rst_n(rst_n),
			.acc_reset(acc_reset),
			.wr_en(wr_en),
			.wr_data(acc_word),
			.rd_addr(rd_addr[ch]),
			.rd_data(acc_rd_data[ch]),
			.wr_ptr(wr_ptr[ch])
		);

		// same writes as the accumulated buffer, so same pointer
		shot_buffer #(.entry_t(meas_word_t)) u_meas_buf (
			.dspif(dspif),
			.rst_n(rst_n),
			.acc_reset(acc_reset),
			.wr_en(wr_en),
			.wr_data(meas_word),
			.rd_addr(rd_addr[ch]),
			.rd_data(meas_rd_data[ch]),
			.wr_ptr()
		);
	end

	meas_aggregator u_agg (
		.dspif(dspif),
		.rst_n(rst_n),
		.proc_reset(proc_reset),
		.meas_valid(meas_valid),
		.meas_bit(meas_bit),
		.meas_state(meas_state),
		.meas_ready(meas_ready)
	);

endmodule

//--- dv/tb_readout.sv
/*
 readout testbench
 table driven experiments with a processor model, checks shot sequencing,
 result buffers and the measurement aggregator
*/
module tb_readout;
	timeunit 1ns;
	timeprecision 1ps;
	import readout_pkg::*;

	localparam int TIMEOUT = 500;
	localparam int NROWS = 6;

	logic dspif = 1'b0;
	logic rst_n;
	logic stb_start;
	logic [SHOT_W-1:0] nshot;
	logic proc_done;
	logic elem_idle;
	logic acc_reset;
	logic [NCHAN-1:0] acc_valid;
	logic signed [ACC_W-1:0] acc_x [NCHAN];
	logic signed [ACC_W-1:0] acc_y [NCHAN];
	buf_addr_t rd_addr [NCHAN];
	logic proc_reset;
	logic last_shot_done;
	logic [SHOT_W-1:0] shot_idx;
	acc_word_t acc_rd_data [NCHAN];
	meas_word_t meas_rd_data [NCHAN];
	buf_addr_t wr_ptr [NCHAN];
	logic [NCHAN-1:0] meas_state;
	logic meas_ready;

	// shots per row
	// 0 is an endless run stopped after 6 shots
	int tab_nshot [NROWS] = '{1, 2, 3, 4, 18, 0};
	// rows 0 to 3 in shot order
	// columns re ch0, im ch0, re ch1, im ch1
	logic [31:0] tab_val [10][4] = '{
		'{32'h0000_1234, 32'h0000_0042, 32'hffff_f000, 32'h0000_0007},
		'{32'h8000_0000, 32'h7fff_ffff, 32'h7fff_ffff, 32'h8000_0001},
		'{32'hffff_ffff, 32'h1234_5678, 32'h0000_0000, 32'hffff_fffe},
		'{32'h0001_0000, 32'hdead_beef, 32'hc000_0000, 32'h0bad_cafe},
		'{32'hfedc_ba98, 32'h0000_0100, 32'h0000_0001, 32'h1357_9bdf},
		'{32'h4000_0000, 32'hffff_0000, 32'h8765_4321, 32'h0000_ffff},
		'{32'ha5a5_a5a5, 32'h5a5a_5a5a, 32'h3c3c_3c3c, 32'hc3c3_c3c3},
		'{32'h0000_0010, 32'h0000_0020, 32'h0000_0030, 32'h0000_0040},
		'{32'hff00_ff00, 32'h00ff_00ff, 32'hf0f0_f0f0, 32'h0f0f_0f0f},
		'{32'h7654_3210, 32'h89ab_cdef, 32'h9999_0000, 32'h0000_9999}
	};

	// values applied in each shot of the current row
	logic [31:0] hist_re [32][NCHAN];
	logic [31:0] hist_im [32][NCHAN];

	int seed = 32'h150ec234;
	int tab_pos = 0;
	// low periods of proc_reset and meas_ready strobes seen so far
	int low_count = 0;
	int ready_count = 0;
	logic seen_reset = 1'b1;
	logic [NCHAN-1:0] ready_state;

	readout_top DUT (.*);

	always #5 dspif = ~dspif;

	// monitor samples settled values at each edge
	always @(posedge dspif) begin
		seen_reset <= proc_reset;
		if (seen_reset && !proc_reset)
			low_count <= low_count + 1;
		if (meas_ready) begin
			ready_count <= ready_count + 1;
			ready_state <= meas_state;
		end
	end

	task automatic step(input int n);
		repeat (n) begin
			@(posedge dspif);
			#1;
		end
	endtask

	task automatic check_eq(input string name, input logic [63:0] exp, input logic [63:0] act);
		if (act !== exp) begin
			$display("[ERROR] %s expected %0h actual %0h", name, exp, act);
			$display("TEST FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	// sel 0 watches proc_reset and sel 1 watches last_shot_done
	task automatic wait_for(input int sel, input logic level, input string what);
		int n;
		n = 0;
		while (((sel == 0) ? proc_reset : last_shot_done) !== level) begin
			if (n == TIMEOUT) begin
				$display("timeout while waiting for %s", what);
				$display("TEST FAILED");
				$fatal(1, "timeout");
			end else begin
				step(1);
				n++;
			end
		end
	endtask

	// processor model for one shot from reset release to idle elements
	task automatic serve_shot(input int k, input int base_low, input int base_ready);
		int dly;
		int ch;
		logic [NCHAN-1:0] signs;
		wait_for(0, 1'b0, "proc_reset release");
		elem_idle = 1'b0;
		check_eq($sformatf("shot_idx in shot %0d", k), 64'(k), 64'(shot_idx));
		for (ch = 0; ch < NCHAN; ch++) begin
			acc_x[ch] = hist_re[k][ch];
			acc_y[ch] = hist_im[k][ch];
			// negative real part is state 1
			signs[ch] = hist_re[k][ch][ACC_W-1];
		end
		acc_valid = '1;
		step(1);
		acc_valid = '0;
		dly = 3 + ($unsigned($random(seed)) % 6);
		step(dly);
		proc_done = 1'b1;
		wait_for(0, 1'b1, "proc_reset after proc_done");
		proc_done = 1'b0;
		check_eq($sformatf("low periods at shot %0d", k), 64'(k + 1), 64'(low_count - base_low));
		check_eq($sformatf("meas_ready at shot %0d", k), 64'(k + 1),
			64'(ready_count - base_ready));
		check_eq($sformatf("meas_state at shot %0d", k), 64'(signs), 64'(ready_state));
		// elements drain a little later
		dly = 1 + ($unsigned($random(seed)) % 8);
		step(dly);
		elem_idle = 1'b1;
	endtask

	task automatic run_row(input int r);
		int n;
		int shots;
		int base_low;
		int base_ready;
		int k;
		int a;
		int ch;
		n = tab_nshot[r];
		shots = (n == 0) ? 6 : n;
		for (k = 0; k < shots; k++) begin
			for (ch = 0; ch < NCHAN; ch++) begin
				hist_re[k][ch] = (r < 4) ? tab_val[tab_pos][2 * ch] : $random(seed);
				hist_im[k][ch] = (r < 4) ? tab_val[tab_pos][2 * ch + 1] : $random(seed);
			end
			if (r < 4)
				tab_pos++;
		end
		// empty buffers for every row
		acc_reset = 1'b1;
		step(1);
		acc_reset = 1'b0;
		base_low = low_count;
		base_ready = ready_count;
		nshot = SHOT_W'(n);
		stb_start = 1'b1;
		step(1);
		stb_start = 1'b0;
		check_eq($sformatf("row %0d last_shot_done clear", r), 64'(0), 64'(last_shot_done));
		for (k = 0; k < shots; k++)
			serve_shot(k, base_low, base_ready);
		if (n != 0) begin
			wait_for(1, 1'b1, "last_shot_done");
			check_eq($sformatf("row %0d low periods", r), 64'(n), 64'(low_count - base_low));
			step(4);
			check_eq($sformatf("row %0d last_shot_done held", r), 64'(1), 64'(last_shot_done));
			elem_idle = 1'b0;
		end else begin
			step(8);
			check_eq("endless run last_shot_done", 64'(0), 64'(last_shot_done));
		end
		// pointer locks at 15 and address 15 then holds the newest shot
		for (ch = 0; ch < NCHAN; ch++)
			check_eq($sformatf("row %0d ch %0d wr_ptr", r, ch), 64'((shots > 15) ? 15 : shots),
				64'(wr_ptr[ch]));
		for (a = 0; a < ((shots > 16) ? 16 : shots); a++) begin
			k = (a == 15) ? shots - 1 : a;
			for (ch = 0; ch < NCHAN; ch++)
				rd_addr[ch] = buf_addr_t'(a);
			step(1);
			for (ch = 0; ch < NCHAN; ch++) begin
				check_eq($sformatf("row %0d ch %0d acc word %0d", r, ch, a),
					{hist_re[k][ch], hist_im[k][ch]}, acc_rd_data[ch]);
				check_eq($sformatf("row %0d ch %0d meas word %0d", r, ch, a),
					64'({hist_re[k][ch][ACC_W-1], 16'(k)}), 64'(meas_rd_data[ch]));
			end
		end
		if (shots > 16) begin
			acc_reset = 1'b1;
			step(1);
			acc_reset = 1'b0;
			for (ch = 0; ch < NCHAN; ch++)
				check_eq($sformatf("ch %0d wr_ptr after acc_reset", ch), 64'(0),
					64'(wr_ptr[ch]));
		end
	endtask

	initial begin
		rst_n = 1'b0;
		stb_start = 1'b0;
		nshot = '0;
		proc_done = 1'b0;
		elem_idle = 1'b0;
		acc_reset = 1'b0;
		acc_valid = '0;
		acc_x = '{default: '0};
		acc_y = '{default: '0};
		rd_addr = '{default: '0};
		repeat (5) @(posedge dspif);
		#1;
		rst_n = 1'b1;
		step(2);
		for (int r = 0; r < NROWS; r++)
			run_row(r);
		$display("TEST PASSED");
		$finish;
	end

endmodule

//--- sim.f
src/readout_pkg.sv
src/shot_sequencer.sv
src/meas_discriminator.sv
src/shot_buffer.sv
src/meas_aggregator.sv
src/readout_top.sv
dv/tb_readout.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_readout
FILELIST = sim.f
LOG      = sim.log
OBJ      = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./$(OBJ)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "TEST PASSED" $(LOG); then echo "simulation did not finish"; exit 1; fi

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ) $(LOG)
